//--- logic/branchPkg.sv
`default_nettype none

package branchPkg;

    // operand and address width, one MIPS word
    localparam int unsigned DataW = 32;

    typedef logic [DataW-1:0] word_t;

    // immediate field of an I-type branch
    localparam int unsigned OffW = 16;

    typedef logic [OffW-1:0] off_t;

    // branch conditions as delivered by decode
    // codes 6 and 7 are not assigned
    typedef enum logic [2:0] {
        CondBeq  = 3'd0,  // rs == rt
        CondBne  = 3'd1,  // rs != rt
        CondBgez = 3'd2,  // rs >= 0
        CondBgtz = 3'd3,  // rs > 0
        CondBlez = 3'd4,  // rs <= 0
        CondBltz = 3'd5   // rs < 0
    } brCond_e;

    // 2-bit saturating direction counter
    // 00 strong not-taken, 01 weak not-taken
    // 10 weak taken, 11 strong taken
    typedef logic [1:0] ctr_t;

    // weakly not-taken after reset
    localparam ctr_t CtrInit = 2'b01;

endpackage

`default_nettype wire

//--- logic/branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

module branchPredictor #(
    parameter int unsigned IdxW = 6  // table index width
) (
    input  wire                   clk_i,
    input  wire                   arstN_i,

    // lookup side, one per branch strobe
    input  wire                   lookValid_i,
    input  wire branchPkg::word_t lookPc_i,

    // training side, from the resolve stage
    input  wire                   updValid_i,
    input  wire branchPkg::word_t updPc_i,
    input  wire                   updTaken_i,

    output logic                  predValid_o,
    output logic                  predTaken_o
);

    localparam int unsigned Entries = 2 ** IdxW;

    branchPkg::ctr_t ctrTable [Entries];  // direction counters

    logic [IdxW-1:0] lookIdx;
    logic [IdxW-1:0] updIdx;

    branchPkg::ctr_t ctrCur;   // counter being trained
    branchPkg::ctr_t ctrNext;  // its next value

    // word-aligned PCs, so the two low bits carry nothing
    assign lookIdx = lookPc_i[IdxW+1:2];
    assign updIdx  = updPc_i[IdxW+1:2];

    // one saturating step toward the real outcome
    always_comb begin
        ctrCur  = ctrTable[updIdx];
        ctrNext = ctrCur;
        if (updTaken_i) begin
            if (ctrCur != 2'b11) begin
                ctrNext = ctrCur + 2'd1;
            end
        end else begin
            if (ctrCur != 2'b00) begin
                ctrNext = ctrCur - 2'd1;
            end
        end
    end

    // training write lands at the end of the result cycle
    // a lookup on the same edge still reads the old counter
    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < Entries; i++) begin
                ctrTable[i] <= branchPkg::CtrInit;
            end
        end else if (updValid_i) begin
            ctrTable[updIdx] <= ctrNext;
        end
    end

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            predValid_o <= 1'b0;
        end else begin
            predValid_o <= lookValid_i;
        end
    end

    // direction is the counter's upper bit
    always_ff @(posedge clk_i) begin
        if (lookValid_i) begin
            predTaken_o <= ctrTable[lookIdx][1];
        end
    end

    // an unknown PC would pick an unknown entry
    // and poison both prediction and later training
    lookPcKnown: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        lookValid_i |-> !$isunknown(lookPc_i)
    ) else $error("branchPredictor: lookup PC has unknown bits");

endmodule

`default_nettype wire

//--- logic/branchCheck.sv
`timescale 1ns/1ps
`default_nettype none

module branchCheck (
    input  wire                      clk_i,
    input  wire                      arstN_i,

    input  wire                      brValid_i,
    input  wire branchPkg::word_t    brPc_i,
    input  wire branchPkg::brCond_e  brCond_i,
    input  wire branchPkg::word_t    rsVal_i,
    input  wire branchPkg::word_t    rtVal_i,
    input  wire branchPkg::off_t     brOff_i,

    output logic                     chkValid_o,
    output branchPkg::word_t         chkPc_o,
    output logic                     chkTaken_o,
    output branchPkg::word_t         chkTarget_o
);

    logic signed [branchPkg::DataW-1:0] rsS;  // rs seen as two's complement

    logic             taken;
    branchPkg::word_t pcPlus4;
    branchPkg::word_t offExt;  // offset in bytes, sign-extended
    branchPkg::word_t target;

    assign rsS = $signed(rsVal_i);

    // real condition, all compares against zero are signed
    always_comb begin
        case (brCond_i)
            branchPkg::CondBeq:  taken = (rsVal_i == rtVal_i);
            branchPkg::CondBne:  taken = (rsVal_i != rtVal_i);
            branchPkg::CondBgez: taken = (rsS >= 0);
            branchPkg::CondBgtz: taken = (rsS > 0);
            branchPkg::CondBlez: taken = (rsS <= 0);
            branchPkg::CondBltz: taken = (rsS < 0);
            default:             taken = 1'b0;
        endcase
    end

    assign offExt = {{(branchPkg::DataW - branchPkg::OffW - 2){brOff_i[branchPkg::OffW-1]}},
                     brOff_i, 2'b00};
    assign pcPlus4 = brPc_i + branchPkg::DataW'(4);
    assign target  = pcPlus4 + offExt;  // relative to the delay slot

    always_ff @(posedge clk_i or negedge arstN_i) begin
        if (!arstN_i) begin
            chkValid_o <= 1'b0;
        end else begin
            chkValid_o <= brValid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (brValid_i) begin
            chkPc_o     <= brPc_i;
            chkTaken_o  <= taken;
            chkTarget_o <= target;
        end
    end

    // an unassigned code would resolve as not-taken in silence
    condDefined: assert property (
        @(posedge clk_i) disable iff (!arstN_i)
        brValid_i |-> brCond_i inside {branchPkg::CondBeq, branchPkg::CondBne,
                                       branchPkg::CondBgez, branchPkg::CondBgtz,
                                       branchPkg::CondBlez, branchPkg::CondBltz}
    ) else $error("branchCheck: undefined branch condition %0d", brCond_i);

endmodule

`default_nettype wire

//--- logic/branchResolve.sv
`timescale 1ns/1ps
`default_nettype none

module branchResolve (
    // registered prediction
    input  wire                   predValid_i,
    input  wire                   predTaken_i,

    // registered evaluation
    input  wire                   chkValid_i,
    input  wire branchPkg::word_t chkPc_i,
    input  wire                   chkTaken_i,
    input  wire branchPkg::word_t chkTarget_i,

    // result of the branch
    output logic                  resValid_o,
    output branchPkg::word_t      resPc_o,
    output logic                  predTaken_o,
    output logic                  actualTaken_o,
    output logic                  mispredict_o,
    output branchPkg::word_t      redirectPc_o,

    // training request back to the predictor
    output logic                  updValid_o,
    output branchPkg::word_t      updPc_o,
    output logic                  updTaken_o
);

    branchPkg::word_t pcPlus8;  // first instruction past the delay slot
    logic             resolved;

    // both halves were launched by the same strobe
    assign resolved = predValid_i & chkValid_i;

    assign pcPlus8 = chkPc_i + branchPkg::DataW'(8);

    assign resValid_o    = resolved;
    assign resPc_o       = chkPc_i;
    assign predTaken_o   = predTaken_i;
    assign actualTaken_o = chkTaken_i;

    // wrong direction in either sense
    assign mispredict_o = resolved & (predTaken_i ^ chkTaken_i);

    // fetch must go where the branch really went
    assign redirectPc_o = chkTaken_i ? chkTarget_i : pcPlus8;

    // every resolved branch trains its counter
    assign updValid_o = resolved;
    assign updPc_o    = chkPc_i;
    assign updTaken_o = chkTaken_i;

    // predictor and checker each hold one stage of the same strobe
    // a skew between them would pair results of different branches
    always_comb begin
        stagesAligned: assert final (predValid_i === chkValid_i)
            else $error("branchResolve: prediction and evaluation out of step");
    end

endmodule

`default_nettype wire

//--- logic/branchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module branchUnit #(
    parameter int unsigned IdxW = 6  // predictor index width, 2 to 10
) (
    input  wire                      clk_i,
    input  wire                      arstN_i,

    // decoded branch, one-cycle strobe
    input  wire                      brValid_i,
    input  wire branchPkg::word_t    brPc_i,
    input  wire branchPkg::brCond_e  brCond_i,
    input  wire branchPkg::word_t    rsVal_i,
    input  wire branchPkg::word_t    rtVal_i,
    input  wire branchPkg::off_t     brOff_i,

    // result, one cycle after the strobe
    output logic                     resValid_o,
    output branchPkg::word_t         resPc_o,
    output logic                     predTaken_o,
    output logic                     actualTaken_o,
    output logic                     mispredict_o,
    output branchPkg::word_t         redirectPc_o
);

    logic             predValid;
    logic             predTaken;

    logic             chkValid;
    branchPkg::word_t chkPc;
    logic             chkTaken;
    branchPkg::word_t chkTarget;

    logic             updValid;  // training loop back
    branchPkg::word_t updPc;
    logic             updTaken;

    branchPredictor #(
        .IdxW(IdxW)
    ) predictor (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .lookValid_i(brValid_i),
        .lookPc_i   (brPc_i),
        .updValid_i (updValid),
        .updPc_i    (updPc),
        .updTaken_i (updTaken),
        .predValid_o(predValid),
        .predTaken_o(predTaken)
    );

    branchCheck check (
        .clk_i      (clk_i),
        .arstN_i    (arstN_i),
        .brValid_i  (brValid_i),
        .brPc_i     (brPc_i),
        .brCond_i   (brCond_i),
        .rsVal_i    (rsVal_i),
        .rtVal_i    (rtVal_i),
        .brOff_i    (brOff_i),
        .chkValid_o (chkValid),
        .chkPc_o    (chkPc),
        .chkTaken_o (chkTaken),
        .chkTarget_o(chkTarget)
    );

    branchResolve resolve (
        .predValid_i  (predValid),
        .predTaken_i  (predTaken),
        .chkValid_i   (chkValid),
        .chkPc_i      (chkPc),
        .chkTaken_i   (chkTaken),
        .chkTarget_i  (chkTarget),
        .resValid_o   (resValid_o),
        .resPc_o      (resPc_o),
        .predTaken_o  (predTaken_o),
        .actualTaken_o(actualTaken_o),
        .mispredict_o (mispredict_o),
        .redirectPc_o (redirectPc_o),
        .updValid_o   (updValid),
        .updPc_o      (updPc),
        .updTaken_o   (updTaken)
    );

endmodule

`default_nettype wire

//--- tb/tbBranchModel.svh
`ifndef TB_BRANCH_MODEL_SVH
`define TB_BRANCH_MODEL_SVH

// one expected result, queued when its branch is strobed
typedef struct packed {
    logic [31:0]      cyc;         // cycle of the strobe
    branchPkg::word_t pc;
    logic             predTaken;
    logic             taken;
    logic             mispredict;
    branchPkg::word_t redirect;
} expRec_t;

localparam int ModelIdxW = 6;  // dut runs with its default table size

int unsigned ctrModel [2 ** ModelIdxW];  // model of the direction counters

// training owed by the branch strobed one cycle ago (new) and two cycles ago (old)
bit          newValid;
int unsigned newIdx;
bit          newTaken;
bit          oldValid;
int unsigned oldIdx;
bit          oldTaken;

logic [31:0] lfsrState = 32'hbe2897bc;

// taps 32, 22, 2, 1
function automatic bit lfsrBit();
    bit fb;
    fb = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
    lfsrState = {lfsrState[30:0], fb};
    return fb;
endfunction

function automatic logic [31:0] randBits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
        r = {r[30:0], lfsrBit()};
    end
    return r;
endfunction

function automatic int unsigned tableIndex(input branchPkg::word_t pc);
    return (pc >> 2) % (2 ** ModelIdxW);  // word address modulo table size
endfunction

function automatic int unsigned stepCounter(input int unsigned ctr, input bit taken);
    if (taken) begin
        return (ctr == 3) ? 3 : ctr + 1;
    end
    return (ctr == 0) ? 0 : ctr - 1;
endfunction

function automatic void modelReset();
    for (int i = 0; i < 2 ** ModelIdxW; i++) begin
        ctrModel[i] = 1;  // weakly not-taken
    end
    newValid = 1'b0;
    oldValid = 1'b0;
endfunction

// one clock of the model, a write becomes visible two cycles after its strobe
function automatic void modelTick();
    if (oldValid) begin
        ctrModel[oldIdx] = stepCounter(ctrModel[oldIdx], oldTaken);
    end
    oldValid = newValid;
    oldIdx   = newIdx;
    oldTaken = newTaken;
    newValid = 1'b0;
endfunction

function automatic expRec_t refResult(input logic [31:0] cyc, input branchPkg::word_t pc,
                                      input branchPkg::brCond_e cond,
                                      input branchPkg::word_t rs, input branchPkg::word_t rt,
                                      input branchPkg::off_t off);
    expRec_t     r;
    bit          taken;
    int          offBytes;
    int unsigned idx;
    // sign bit and zero test stand in for the signed compares
    case (cond)
        branchPkg::CondBeq:  taken = (rs == rt);
        branchPkg::CondBne:  taken = (rs != rt);
        branchPkg::CondBgez: taken = !rs[31];
        branchPkg::CondBgtz: taken = !rs[31] && (rs != 0);
        branchPkg::CondBlez: taken = rs[31] || (rs == 0);
        branchPkg::CondBltz: taken = rs[31];
        default:             taken = 1'b0;
    endcase
    offBytes = $signed(off);
    offBytes = offBytes * 4;
    idx = tableIndex(pc);
    r.cyc        = cyc;
    r.pc         = pc;
    r.taken      = taken;
    r.predTaken  = (ctrModel[idx] >= 2);
    r.mispredict = (r.predTaken != taken);
    r.redirect   = taken ? pc + 32'd4 + offBytes : pc + 32'd8;
    newValid = 1'b1;  // trains once it resolves
    newIdx   = idx;
    newTaken = taken;
    return r;
endfunction

`endif

//--- tb/tbBranchUnit.sv
`timescale 1ns/1ps
`default_nettype none

module tbBranchUnit;

    localparam int ClkPeriod   = 4;
    localparam int ResetCycles = 10;
    localparam int NumRandom   = 300;
    localparam int MaxGap      = 3;
    // directed tests need well under 150 cycles
    localparam int WatchCycles = ResetCycles + 150 + NumRandom * (MaxGap + 1) + 100;

    logic               clk;
    logic               arstN;
    logic               brValid;
    branchPkg::word_t   brPc;
    branchPkg::brCond_e brCond;
    branchPkg::word_t   rsVal;
    branchPkg::word_t   rtVal;
    branchPkg::off_t    brOff;
    logic               resValid;
    branchPkg::word_t   resPc;
    logic               predTaken;
    logic               actualTaken;
    logic               mispredict;
    branchPkg::word_t   redirectPc;

    int unsigned cycNum      = 0;
    int unsigned strobeCount = 0;
    int unsigned resultCount = 0;
    int unsigned valueErrs   = 0;
    int unsigned protoErrs   = 0;

    `include "tbBranchModel.svh"

    expRec_t expQ [$];
    string   nameQ [$];

    branchUnit dut (
        .clk_i        (clk),
        .arstN_i      (arstN),
        .brValid_i    (brValid),
        .brPc_i       (brPc),
        .brCond_i     (brCond),
        .rsVal_i      (rsVal),
        .rtVal_i      (rtVal),
        .brOff_i      (brOff),
        .resValid_o   (resValid),
        .resPc_o      (resPc),
        .predTaken_o  (predTaken),
        .actualTaken_o(actualTaken),
        .mispredict_o (mispredict),
        .redirectPc_o (redirectPc)
    );

    initial begin : clockGen
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cycNum <= cycNum + 1;
    end

    task automatic checkValue(input string testName, input string field,
                              input logic [31:0] expVal, input logic [31:0] actVal);
        assert (actVal === expVal) else begin
            $display("Fail %s %s: expected %0h, actual %0h", testName, field, expVal, actVal);
            valueErrs++;
        end
    endtask

    task automatic sendBranch(input string testName, input branchPkg::word_t pc,
                              input branchPkg::brCond_e cond, input branchPkg::word_t rs,
                              input branchPkg::word_t rt, input branchPkg::off_t off);
        @(negedge clk);
        modelTick();
        brValid = 1'b1;
        brPc    = pc;
        brCond  = cond;
        rsVal   = rs;
        rtVal   = rt;
        brOff   = off;
        expQ.push_back(refResult(cycNum, pc, cond, rs, rt, off));
        nameQ.push_back(testName);
        strobeCount++;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            modelTick();
            brValid = 1'b0;
        end
    endtask

    initial begin : compareResults
        expRec_t head;
        string   testName;
        @(posedge clk);
        forever begin
            @(negedge clk);
            assert (resValid || !mispredict) else begin
                $display("mispredict_o high without a result in cycle %0d", cycNum);
                protoErrs++;
            end
            // a record strobed in this very cycle is not yet due
            if (resValid) begin
                resultCount++;
                assert (expQ.size() > 0 && expQ[0].cyc < cycNum) else begin
                    $display("result in cycle %0d with no branch outstanding", cycNum);
                    protoErrs++;
                end
            end
            // head is due one cycle after its strobe
            if (expQ.size() > 0 && expQ[0].cyc < cycNum) begin
                head     = expQ.pop_front();
                testName = nameQ.pop_front();
                assert (resValid) else begin
                    $display("no result for %s branch strobed in cycle %0d", testName, head.cyc);
                    protoErrs++;
                end
                if (resValid) begin
                    checkValue(testName, "resPc_o", head.pc, resPc);
                    checkValue(testName, "predTaken_o", head.predTaken, predTaken);
                    checkValue(testName, "actualTaken_o", head.taken, actualTaken);
                    checkValue(testName, "mispredict_o", head.mispredict, mispredict);
                    if (head.taken || head.mispredict) begin
                        checkValue(testName, "redirectPc_o", head.redirect, redirectPc);
                    end
                end
            end
        end
    end

    initial begin : watchdog
        #(WatchCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, run did not finish", WatchCycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin : stimulus
        branchPkg::word_t   vals [5];
        branchPkg::off_t    offs [6];
        branchPkg::word_t   pc;
        branchPkg::word_t   rs;
        branchPkg::word_t   rt;
        branchPkg::brCond_e cond;
        int                 gap;
        brValid = 1'b0;
        brPc    = '0;
        brCond  = branchPkg::CondBeq;
        rsVal   = '0;
        rtVal   = '0;
        brOff   = '0;
        arstN   = 1'b0;
        modelReset();
        repeat (ResetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
        idleCycles(5);  // outputs must stay quiet after reset

        // every condition against zero, one and the extremes
        vals = '{32'h0, 32'h1, 32'h8000_0000, 32'h7fff_ffff, 32'hffff_ffff};
        for (int c = 0; c < 6; c++) begin
            for (int i = 0; i < 5; i++) begin
                rt = (i % 2 == 0) ? vals[i] : vals[(i + 4) % 5];
                sendBranch($sformatf("cond%0d", c), 32'h0040_1000 + (i % 4) * 4,
                           branchPkg::brCond_e'(c), vals[i], rt, 16'h0010);
            end
        end

        offs = '{16'h0000, 16'h0001, 16'h7fff, 16'h8000, 16'hffff, 16'hfff0};
        for (int i = 0; i < 6; i++) begin
            sendBranch("target", 32'h0040_2010 + i * 4, branchPkg::CondBeq,
                       32'h5, 32'h5, offs[i]);
        end
        // train toward taken, then fall through
        sendBranch("target", 32'h0040_3028, branchPkg::CondBgez, 32'h0, 32'h0, 16'h0040);
        idleCycles(1);
        sendBranch("target", 32'h0040_3028, branchPkg::CondBgez, 32'h0, 32'h0, 16'h0040);
        idleCycles(1);
        sendBranch("target", 32'h0040_3028, branchPkg::CondBltz, 32'h0, 32'h0, 16'h0040);

        // four taken, two not-taken, one taken
        for (int i = 0; i < 7; i++) begin
            rt = (i == 4 || i == 5) ? 32'h1 : 32'h2;
            sendBranch("training", 32'h0040_4040, branchPkg::CondBne, 32'h1, rt, 16'h0100);
            idleCycles(2);
        end

        repeat (4) begin
            sendBranch("backToBack", 32'h0040_5080, branchPkg::CondBeq, 32'h7, 32'h7, 16'hff00);
        end
        idleCycles(2);
        // same index bits, so the trained counter is shared
        sendBranch("alias", 32'h0040_5180, branchPkg::CondBeq, 32'h7, 32'h8, 16'hff00);

        for (int n = 0; n < NumRandom; n++) begin
            gap = randBits(1) ? randBits(2) : 0;
            idleCycles(gap);
            cond = branchPkg::brCond_e'(randBits(3) % 6);
            pc   = 32'h0040_0000 | (randBits(5) << 2) | (randBits(1) << 12);
            rs   = randBits(32);
            case (randBits(2))
                0: rt = rs;
                1: begin
                    rs = '0;
                    rt = randBits(32);
                end
                default: rt = randBits(32);
            endcase
            sendBranch("random", pc, cond, rs, rt, branchPkg::off_t'(randBits(16)));
        end

        idleCycles(4);
        assert (expQ.size() == 0 && resultCount == strobeCount) else begin
            $display("%0d results seen for %0d branches, %0d still outstanding",
                     resultCount, strobeCount, expQ.size());
            protoErrs++;
        end
        $display("errors: %0d wrong values, %0d protocol, %0d results checked",
                 valueErrs, protoErrs, resultCount);
        if (valueErrs == 0 && protoErrs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- branchUnit.f
+incdir+tb
logic/branchPkg.sv
logic/branchPredictor.sv
logic/branchCheck.sv
logic/branchResolve.sv
logic/branchUnit.sv
tb/tbBranchUnit.sv

//--- Bender.yml
package:
  name: branch_unit

sources:
  # design
  - files:
      - logic/branchPkg.sv
      - logic/branchPredictor.sv
      - logic/branchCheck.sv
      - logic/branchResolve.sv
      - logic/branchUnit.sv

  # testbench
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tbBranchUnit.sv
